// File: csr_pkg.sv
/*
 * Shared definitions for the machine-mode CSR file.
 * Register width, CSR addresses, command, privilege and select
 * encodings, trap cause codes and CSR write masks.
 */
package csr_pkg;

    // ========================================
    // widths
    // ========================================
    localparam int XLEN_DEFAULT = 64;

    // ========================================
    // encodings
    // ========================================
    typedef enum logic [1:0] {
        CSR_CMD_WR   = 2'd0,
        CSR_CMD_SET  = 2'd1,
        CSR_CMD_CLR  = 2'd2,
        CSR_CMD_READ = 2'd3
    } csr_cmd_e;

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_M = 2'd3
    } priv_lvl_e;

    typedef enum logic [3:0] {
        SEL_MSTATUS,
        SEL_MISA,
        SEL_MIE,
        SEL_MTVEC,
        SEL_MSCRATCH,
        SEL_MEPC,
        SEL_MCAUSE,
        SEL_MTVAL,
        SEL_MIP,
        SEL_MCYCLE,
        SEL_MHARTID,
        SEL_NONE
    } csr_sel_e;

    // ========================================
    // csr addresses
    // ========================================
    localparam logic [11:0] ADDR_MSTATUS  = 12'h300;
    localparam logic [11:0] ADDR_MISA     = 12'h301;
    localparam logic [11:0] ADDR_MIE      = 12'h304;
    localparam logic [11:0] ADDR_MTVEC    = 12'h305;
    localparam logic [11:0] ADDR_MSCRATCH = 12'h340;
    localparam logic [11:0] ADDR_MEPC     = 12'h341;
    localparam logic [11:0] ADDR_MCAUSE   = 12'h342;
    localparam logic [11:0] ADDR_MTVAL    = 12'h343;
    localparam logic [11:0] ADDR_MIP      = 12'h344;
    localparam logic [11:0] ADDR_MCYCLE   = 12'hB00;
    localparam logic [11:0] ADDR_MHARTID  = 12'hF14;

    // ========================================
    // trap causes and interrupt numbers
    // ========================================
    localparam int CAUSE_ILLEGAL_INSTR = 2;
    localparam int CAUSE_ECALL_U       = 8;
    localparam int IRQ_M_SOFT          = 3;
    localparam int IRQ_M_TIMER         = 7;
    localparam int IRQ_M_EXT           = 11;

    // mstatus field positions
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11;

    // ========================================
    // write masks and constants
    // ========================================
    localparam logic [63:0] MIE_WRITE_MASK     = 64'h0000_0000_0000_0888;
    localparam logic [63:0] MSTATUS_WRITE_MASK = 64'h0000_0000_0000_1888;
    localparam logic [63:0] MTVEC_RESET_OFFSET = 64'h40;

    // rv64 with i, m, a and u mode
    localparam logic [XLEN_DEFAULT-1:0] ISA_CODE = 64'h8000_0000_0010_1101;

endpackage

// File: csr_access_check.sv
/*
 * CSR access check.
 * Decodes the CSR address into a register select and flags unknown
 * addresses, privilege violations and writes to read-only CSRs.
 */
`timescale 1ns/1ns

module csr_access_check
    import csr_pkg::*;
#(
    parameter int XLEN = XLEN_DEFAULT
) (
    input  logic        csr_valid_i,
    input  csr_cmd_e    csr_cmd_i,
    input  logic [11:0] csr_addr_i,
    input  priv_lvl_e   priv_lvl_i,
    output csr_sel_e    csr_sel_o,
    output logic        csr_we_o,
    output logic        csr_illegal_o
);

    logic is_write;
    logic unknown_addr;
    logic priv_fault;
    logic ro_fault;

    // only rv32 and rv64 register widths are supported
    if (XLEN != 32 && XLEN != 64) begin : g_xlen_check
        $error("csr_access_check: unsupported XLEN %0d", XLEN);
    end

    // ========================================
    // address decode
    // ========================================
    always_comb begin : addr_decode
        case (csr_addr_i)
            ADDR_MSTATUS:  csr_sel_o = SEL_MSTATUS;
            ADDR_MISA:     csr_sel_o = SEL_MISA;
            ADDR_MIE:      csr_sel_o = SEL_MIE;
            ADDR_MTVEC:    csr_sel_o = SEL_MTVEC;
            ADDR_MSCRATCH: csr_sel_o = SEL_MSCRATCH;
            ADDR_MEPC:     csr_sel_o = SEL_MEPC;
            ADDR_MCAUSE:   csr_sel_o = SEL_MCAUSE;
            ADDR_MTVAL:    csr_sel_o = SEL_MTVAL;
            ADDR_MIP:      csr_sel_o = SEL_MIP;
            ADDR_MCYCLE:   csr_sel_o = SEL_MCYCLE;
            ADDR_MHARTID:  csr_sel_o = SEL_MHARTID;
            default:       csr_sel_o = SEL_NONE;
        endcase
    end

    // ========================================
    // permission checks
    // ========================================
    assign is_write     = (csr_cmd_i != CSR_CMD_READ);
    assign unknown_addr = (csr_sel_o == SEL_NONE);

    // addr[9:8] holds the lowest privilege allowed to touch the csr
    assign priv_fault = (csr_addr_i[9:8] > priv_lvl_i);

    // misa is fixed in this hart, so it joins the read-only space
    assign ro_fault = is_write && ((csr_addr_i[11:10] == 2'b11) || (csr_sel_o == SEL_MISA));

    assign csr_illegal_o = csr_valid_i && (unknown_addr || priv_fault || ro_fault);
    assign csr_we_o      = csr_valid_i && is_write && !csr_illegal_o;

endmodule

// File: csr_machine_regs.sv
/*
 * Machine register bank.
 * Holds mstatus, mie, mip, mtvec, mscratch, mepc, mcause, mtval,
 * mcycle and the privilege level. Provides the CSR read mux and
 * applies CSR writes, trap entry and mret.
 */
`timescale 1ns/1ns

module csr_machine_regs
    import csr_pkg::*;
#(
    parameter int XLEN = XLEN_DEFAULT
) (
    input  logic            clk_i,
    input  logic            mtvec_rst_load_q,
    input  logic [XLEN-1:0] boot_addr_i,
    input  logic [XLEN-1:0] hart_id_i,
    input  csr_sel_e        csr_sel_i,
    input  logic            csr_we_i,
    input  csr_cmd_e        csr_cmd_i,
    input  logic [XLEN-1:0] csr_wdata_i,
    input  logic            trap_take_i,
    input  logic [XLEN-1:0] trap_cause_i,
    input  logic [XLEN-1:0] trap_tval_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic            mret_i,
    input  logic            irq_ext_i,
    input  logic            irq_timer_i,
    input  logic            irq_soft_i,
    output logic [XLEN-1:0] csr_rdata_o,
    output logic [XLEN-1:0] mtvec_o,
    output logic [XLEN-1:0] mepc_o,
    output logic [XLEN-1:0] mie_o,
    output logic [XLEN-1:0] mip_o,
    output logic            mstatus_mie_o,
    output priv_lvl_e       priv_lvl_o,
    output logic            eret_o,
    output logic            flush_o
);

    localparam logic [XLEN-1:0] MIE_MASK     = MIE_WRITE_MASK[XLEN-1:0];
    localparam logic [XLEN-1:0] MSTATUS_MASK = MSTATUS_WRITE_MASK[XLEN-1:0];
    localparam logic [XLEN-1:0] MTVEC_OFFSET = MTVEC_RESET_OFFSET[XLEN-1:0];

    logic [XLEN-1:0] mstatus_q,  mstatus_d;
    logic [XLEN-1:0] mie_q,      mie_d;
    logic [XLEN-1:0] mip_q,      mip_d;
    logic [XLEN-1:0] mtvec_q,    mtvec_d;
    logic [XLEN-1:0] mscratch_q, mscratch_d;
    logic [XLEN-1:0] mepc_q,     mepc_d;
    logic [XLEN-1:0] mcause_q,   mcause_d;
    logic [XLEN-1:0] mtval_q,    mtval_d;
    logic [XLEN-1:0] mcycle_q,   mcycle_d;
    priv_lvl_e       priv_lvl_q, priv_lvl_d;

    logic [XLEN-1:0] csr_wdata;
    logic            csr_write;

    // ========================================
    // read mux
    // ========================================
    always_comb begin : read_mux
        case (csr_sel_i)
            SEL_MSTATUS:  csr_rdata_o = mstatus_q;
            SEL_MISA:     csr_rdata_o = ISA_CODE[XLEN-1:0];
            SEL_MIE:      csr_rdata_o = mie_q;
            SEL_MTVEC:    csr_rdata_o = mtvec_q;
            SEL_MSCRATCH: csr_rdata_o = mscratch_q;
            SEL_MEPC:     csr_rdata_o = mepc_q;
            SEL_MCAUSE:   csr_rdata_o = mcause_q;
            SEL_MTVAL:    csr_rdata_o = mtval_q;
            SEL_MIP:      csr_rdata_o = mip_q;
            SEL_MCYCLE:   csr_rdata_o = mcycle_q;
            SEL_MHARTID:  csr_rdata_o = hart_id_i;
            default:      csr_rdata_o = '0;
        endcase
    end

    // write value per command
    always_comb begin : wdata_gen
        case (csr_cmd_i)
            CSR_CMD_SET:  csr_wdata = csr_rdata_o | csr_wdata_i;
            CSR_CMD_CLR:  csr_wdata = csr_rdata_o & ~csr_wdata_i;
            CSR_CMD_READ: csr_wdata = csr_rdata_o;
            default:      csr_wdata = csr_wdata_i;
        endcase
    end

    // a trap in the same cycle cancels the write
    assign csr_write = csr_we_i && !trap_take_i;

    // ========================================
    // next state
    // ========================================
    always_comb begin : next_state
        mstatus_d  = mstatus_q;
        mie_d      = mie_q;
        mtvec_d    = mtvec_q;
        mscratch_d = mscratch_q;
        mepc_d     = mepc_q;
        mcause_d   = mcause_q;
        mtval_d    = mtval_q;
        mcycle_d   = mcycle_q + 1'b1;
        priv_lvl_d = priv_lvl_q;

        // mip follows the interrupt lines only
        mip_d              = '0;
        mip_d[IRQ_M_SOFT]  = irq_soft_i;
        mip_d[IRQ_M_TIMER] = irq_timer_i;
        mip_d[IRQ_M_EXT]   = irq_ext_i;

        if (csr_write) begin
            case (csr_sel_i)
                SEL_MSTATUS: begin
                    mstatus_d = (mstatus_q & ~MSTATUS_MASK) | (csr_wdata & MSTATUS_MASK);
                    // mpp holds only M or U
                    if (csr_wdata[MSTATUS_MPP_LSB +: 2] != PRIV_M) begin
                        mstatus_d[MSTATUS_MPP_LSB +: 2] = PRIV_U;
                    end
                end
                SEL_MIE:      mie_d = (mie_q & ~MIE_MASK) | (csr_wdata & MIE_MASK);
                SEL_MTVEC: begin
                    mtvec_d = {csr_wdata[XLEN-1:2], 1'b0, csr_wdata[0]};
                    // vectored base is 256 byte aligned
                    if (csr_wdata[0]) begin
                        mtvec_d[7:2] = '0;
                    end
                end
                SEL_MSCRATCH: mscratch_d = csr_wdata;
                SEL_MEPC:     mepc_d = {csr_wdata[XLEN-1:1], 1'b0};
                SEL_MCAUSE:   mcause_d = csr_wdata;
                SEL_MTVAL:    mtval_d = csr_wdata;
                SEL_MCYCLE:   mcycle_d = csr_wdata;
                default: ;
            endcase
        end

        if (trap_take_i) begin
            mepc_d                       = pc_i;
            mcause_d                     = trap_cause_i;
            mtval_d                      = trap_tval_i;
            mstatus_d[MSTATUS_MPIE_BIT]  = mstatus_q[MSTATUS_MIE_BIT];
            mstatus_d[MSTATUS_MIE_BIT]   = 1'b0;
            mstatus_d[MSTATUS_MPP_LSB +: 2] = priv_lvl_q;
            priv_lvl_d                   = PRIV_M;
        end else if (mret_i) begin
            mstatus_d[MSTATUS_MIE_BIT]   = mstatus_q[MSTATUS_MPIE_BIT];
            mstatus_d[MSTATUS_MPIE_BIT]  = 1'b1;
            priv_lvl_d                   = priv_lvl_e'(mstatus_q[MSTATUS_MPP_LSB +: 2]);
            mstatus_d[MSTATUS_MPP_LSB +: 2] = PRIV_U;
        end
    end

    // ========================================
    // registers
    // ========================================
    always_ff @(posedge clk_i) begin
        if (mtvec_rst_load_q) begin
            mstatus_q  <= '0;
            mie_q      <= '0;
            mip_q      <= '0;
            // trap base sits just above the boot address
            mtvec_q    <= boot_addr_i + MTVEC_OFFSET;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtval_q    <= '0;
            mcycle_q   <= '0;
            priv_lvl_q <= PRIV_M;
        end else begin
            mstatus_q  <= mstatus_d;
            mie_q      <= mie_d;
            mip_q      <= mip_d;
            mtvec_q    <= mtvec_d;
            mscratch_q <= mscratch_d;
            mepc_q     <= mepc_d;
            mcause_q   <= mcause_d;
            mtval_q    <= mtval_d;
            mcycle_q   <= mcycle_d;
            priv_lvl_q <= priv_lvl_d;
        end
    end

    assign mtvec_o       = mtvec_q;
    assign mepc_o        = mepc_q;
    assign mie_o         = mie_q;
    assign mip_o         = mip_q;
    assign mstatus_mie_o = mstatus_q[MSTATUS_MIE_BIT];
    assign priv_lvl_o    = priv_lvl_q;
    assign eret_o        = mret_i && !trap_take_i;
    // mstatus changes the interrupt context of younger instructions
    assign flush_o       = csr_write && (csr_sel_i == SEL_MSTATUS);

endmodule

// File: csr_trap_unit.sv
/*
 * Trap unit.
 * Picks the trap cause, forms the trap vector from mtvec, returns
 * mepc as the exception return pc and flags pending interrupts.
 */
`timescale 1ns/1ns

module csr_trap_unit
    import csr_pkg::*;
#(
    parameter int XLEN = XLEN_DEFAULT
) (
    input  logic            csr_illegal_i,
    input  logic [31:0]     csr_instr_i,
    input  logic            ex_valid_i,
    input  logic [XLEN-1:0] ex_cause_i,
    input  logic [XLEN-1:0] ex_tval_i,
    input  logic [XLEN-1:0] mtvec_i,
    input  logic [XLEN-1:0] mepc_i,
    input  logic [XLEN-1:0] mie_i,
    input  logic [XLEN-1:0] mip_i,
    input  logic            mstatus_mie_i,
    input  priv_lvl_e       priv_lvl_i,
    output logic            trap_take_o,
    output logic [XLEN-1:0] trap_cause_o,
    output logic [XLEN-1:0] trap_tval_o,
    output logic            ex_valid_o,
    output logic [XLEN-1:0] trap_vec_o,
    output logic [XLEN-1:0] epc_o,
    output logic            irq_pending_o
);

    logic irq_enabled;

    // ========================================
    // cause select
    // ========================================
    always_comb begin : cause_sel
        trap_cause_o = '0;
        trap_tval_o  = '0;
        // illegal csr access wins over the incoming exception
        if (csr_illegal_i) begin
            trap_cause_o = XLEN'(CAUSE_ILLEGAL_INSTR);
            trap_tval_o  = {{(XLEN-32){1'b0}}, csr_instr_i};
        end else if (ex_valid_i) begin
            trap_cause_o = ex_cause_i;
            trap_tval_o  = ex_tval_i;
        end
    end

    assign trap_take_o = csr_illegal_i || ex_valid_i;
    assign ex_valid_o  = trap_take_o;

    // ========================================
    // trap vector
    // ========================================
    always_comb begin : trap_vec_gen
        trap_vec_o = {mtvec_i[XLEN-1:2], 2'b00};
        // vectored mode, interrupts jump to base + 4 * cause
        if (mtvec_i[0] && trap_cause_o[XLEN-1]) begin
            trap_vec_o[7:2] = trap_cause_o[5:0];
        end
    end

    assign epc_o = mepc_i;

    // interrupts always reach M mode from U mode
    assign irq_enabled   = (priv_lvl_i == PRIV_U) || mstatus_mie_i;
    assign irq_pending_o = (|(mie_i & mip_i)) && irq_enabled;

endmodule

// File: csr_regfile_top.sv
/*
 * Machine-mode CSR file of a two-level (M/U) RISC-V hart.
 * Connects the access check, the machine register bank and the
 * trap unit.
 */
`timescale 1ns/1ns

module csr_regfile_top
    import csr_pkg::*;
#(
    parameter int XLEN = XLEN_DEFAULT
) (
    input  logic            clk_i,
    input  logic            mtvec_rst_load_q,
    input  logic [XLEN-1:0] boot_addr_i,
    input  logic [XLEN-1:0] hart_id_i,
    // csr operation
    input  logic            csr_valid_i,
    input  csr_cmd_e        csr_cmd_i,
    input  logic [11:0]     csr_addr_i,
    input  logic [XLEN-1:0] csr_wdata_i,
    output logic [XLEN-1:0] csr_rdata_o,
    input  logic [31:0]     csr_instr_i,
    input  logic [XLEN-1:0] pc_i,
    // exception and return
    input  logic            ex_valid_i,
    input  logic [XLEN-1:0] ex_cause_i,
    input  logic [XLEN-1:0] ex_tval_i,
    input  logic            mret_i,
    // interrupt lines
    input  logic            irq_ext_i,
    input  logic            irq_timer_i,
    input  logic            irq_soft_i,
    // to pipeline control
    output logic            ex_valid_o,
    output logic [XLEN-1:0] trap_vec_o,
    output logic            eret_o,
    output logic [XLEN-1:0] epc_o,
    output logic            flush_o,
    output logic            irq_pending_o,
    output priv_lvl_e       priv_lvl_o
);

    csr_sel_e        csr_sel;
    logic            csr_we;
    logic            csr_illegal;
    logic            trap_take;
    logic [XLEN-1:0] trap_cause;
    logic [XLEN-1:0] trap_tval;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mie;
    logic [XLEN-1:0] mip;
    logic            mstatus_mie;

    csr_access_check #(
        .XLEN (XLEN)
    ) u_csr_access_check (
        .csr_valid_i   (csr_valid_i),
        .csr_cmd_i     (csr_cmd_i),
        .csr_addr_i    (csr_addr_i),
        .priv_lvl_i    (priv_lvl_o),
        .csr_sel_o     (csr_sel),
        .csr_we_o      (csr_we),
        .csr_illegal_o (csr_illegal)
    );

    csr_machine_regs #(
        .XLEN (XLEN)
    ) u_csr_machine_regs (
        .clk_i            (clk_i),
        .mtvec_rst_load_q (mtvec_rst_load_q),
        .boot_addr_i      (boot_addr_i),
        .hart_id_i        (hart_id_i),
        .csr_sel_i        (csr_sel),
        .csr_we_i         (csr_we),
        .csr_cmd_i        (csr_cmd_i),
        .csr_wdata_i      (csr_wdata_i),
        .trap_take_i      (trap_take),
        .trap_cause_i     (trap_cause),
        .trap_tval_i      (trap_tval),
        .pc_i             (pc_i),
        .mret_i           (mret_i),
        .irq_ext_i        (irq_ext_i),
        .irq_timer_i      (irq_timer_i),
        .irq_soft_i       (irq_soft_i),
        .csr_rdata_o      (csr_rdata_o),
        .mtvec_o          (mtvec),
        .mepc_o           (mepc),
        .mie_o            (mie),
        .mip_o            (mip),
        .mstatus_mie_o    (mstatus_mie),
        .priv_lvl_o       (priv_lvl_o),
        .eret_o           (eret_o),
        .flush_o          (flush_o)
    );

    csr_trap_unit #(
        .XLEN (XLEN)
    ) u_csr_trap_unit (
        .csr_illegal_i (csr_illegal),
        .csr_instr_i   (csr_instr_i),
        .ex_valid_i    (ex_valid_i),
        .ex_cause_i    (ex_cause_i),
        .ex_tval_i     (ex_tval_i),
        .mtvec_i       (mtvec),
        .mepc_i        (mepc),
        .mie_i         (mie),
        .mip_i         (mip),
        .mstatus_mie_i (mstatus_mie),
        .priv_lvl_i    (priv_lvl_o),
        .trap_take_o   (trap_take),
        .trap_cause_o  (trap_cause),
        .trap_tval_o   (trap_tval),
        .ex_valid_o    (ex_valid_o),
        .trap_vec_o    (trap_vec_o),
        .epc_o         (epc_o),
        .irq_pending_o (irq_pending_o)
    );

endmodule

// File: csr_regfile_checker.sv
/*
 * Assertions on the CSR file outputs.
 * Bound into the top level of the CSR file.
 */
`timescale 1ns/1ns

module csr_regfile_checker
    import csr_pkg::*;
#(
    parameter int XLEN = XLEN_DEFAULT
) (
    input logic            clk_i,
    input logic            mtvec_rst_load_q,
    input logic            ex_valid_o,
    input logic            eret_o,
    input logic            flush_o,
    input priv_lvl_e       priv_lvl_o,
    input logic [XLEN-1:0] trap_vec_o
);

    int assert_fail_cnt = 0;

    // trap and return never leave in the same cycle
    a_ex_eret_excl: assert property (@(posedge clk_i) disable iff (mtvec_rst_load_q)
        !(ex_valid_o && eret_o))
        else begin
            assert_fail_cnt++;
            $error("ex_valid_o and eret_o are high together");
        end

    a_priv_legal: assert property (@(posedge clk_i) disable iff (mtvec_rst_load_q)
        priv_lvl_o inside {PRIV_M, PRIV_U})
        else begin
            assert_fail_cnt++;
            $error("priv_lvl_o holds an unsupported level");
        end

    // trap targets are word aligned
    a_vec_aligned: assert property (@(posedge clk_i) disable iff (mtvec_rst_load_q)
        trap_vec_o[1:0] == 2'b00)
        else begin
            assert_fail_cnt++;
            $error("trap_vec_o is not word aligned");
        end

    a_no_flush_on_trap: assert property (@(posedge clk_i) disable iff (mtvec_rst_load_q)
        ex_valid_o |-> !flush_o)
        else begin
            assert_fail_cnt++;
            $error("flush_o is high during a trap");
        end

endmodule

bind csr_regfile_top csr_regfile_checker #(
    .XLEN (XLEN)
) u_csr_regfile_checker (
    .clk_i            (clk_i),
    .mtvec_rst_load_q (mtvec_rst_load_q),
    .ex_valid_o       (ex_valid_o),
    .eret_o           (eret_o),
    .flush_o          (flush_o),
    .priv_lvl_o       (priv_lvl_o),
    .trap_vec_o       (trap_vec_o)
);

// File: tb_csr_regfile.sv
/*
 * Directed testbench for the machine-mode CSR file.
 * Covers reset values, CSR commands, illegal accesses, trap entry,
 * mret and the machine interrupt path.
 */
`timescale 1ns/1ns

module tb_csr_regfile
    import csr_pkg::*;
();

    localparam int          XLEN      = XLEN_DEFAULT;
    localparam logic [63:0] BOOT_ADDR = 64'h0000_0000_8000_0000;

    logic            clk_i = 1'b0;
    logic            mtvec_rst_load_q;
    logic [XLEN-1:0] boot_addr_i;
    logic [XLEN-1:0] hart_id_i;
    logic            csr_valid_i;
    csr_cmd_e        csr_cmd_i;
    logic [11:0]     csr_addr_i;
    logic [XLEN-1:0] csr_wdata_i;
    logic [XLEN-1:0] csr_rdata_o;
    logic [31:0]     csr_instr_i;
    logic [XLEN-1:0] pc_i;
    logic            ex_valid_i;
    logic [XLEN-1:0] ex_cause_i;
    logic [XLEN-1:0] ex_tval_i;
    logic            mret_i;
    logic            irq_ext_i;
    logic            irq_timer_i;
    logic            irq_soft_i;
    logic            ex_valid_o;
    logic [XLEN-1:0] trap_vec_o;
    logic            eret_o;
    logic [XLEN-1:0] epc_o;
    logic            flush_o;
    logic            irq_pending_o;
    priv_lvl_e       priv_lvl_o;

    int          err_cnt;
    int          check_cnt;
    int          test_err_base;
    logic [15:0] lfsr_q;

    always #4 clk_i = ~clk_i;

    csr_regfile_top #(
        .XLEN (XLEN)
    ) u_csr_regfile_top (.*);

    // ========================================
    // helpers
    // ========================================
    // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    task automatic rand64(output logic [63:0] v);
        for (int i = 0; i < 64; i++) begin
            v[i]   = lfsr_q[0];
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("CHECK FAILED time %0t ns: %s expected 0x%0h actual 0x%0h",
                     $time, name, exp, act);
        end
    endtask

    // one csr operation per cycle, outputs sampled 1 ns after the falling edge
    task automatic drive_op(input csr_cmd_e cmd, input logic [11:0] addr,
                            input logic [63:0] wdata, input logic [31:0] instr = 32'h0);
        @(negedge clk_i);
        csr_valid_i = 1'b1;
        csr_cmd_i   = cmd;
        csr_addr_i  = addr;
        csr_wdata_i = wdata;
        csr_instr_i = instr;
        ex_valid_i  = 1'b0;
        mret_i      = 1'b0;
        #1;
    endtask

    task automatic drive_idle();
        @(negedge clk_i);
        csr_valid_i = 1'b0;
        csr_cmd_i   = CSR_CMD_READ;
        ex_valid_i  = 1'b0;
        mret_i      = 1'b0;
        #1;
    endtask

    task automatic raise_exception(input logic [63:0] cause, input logic [63:0] tval,
                                   input logic [63:0] pc);
        @(negedge clk_i);
        csr_valid_i = 1'b0;
        ex_valid_i  = 1'b1;
        ex_cause_i  = cause;
        ex_tval_i   = tval;
        pc_i        = pc;
        #1;
    endtask

    task automatic pulse_mret();
        @(negedge clk_i);
        csr_valid_i = 1'b0;
        mret_i      = 1'b1;
        #1;
    endtask

    task automatic expect_csr(input logic [11:0] addr, input logic [63:0] exp, input string name);
        drive_op(CSR_CMD_READ, addr, '0);
        check_val(name, exp, csr_rdata_o);
    endtask

    task automatic wait_irq(input logic level, input int limit);
        int n;
        n = 0;
        while (irq_pending_o !== level && n < limit) begin
            @(negedge clk_i);
            #1;
            n++;
        end
        if (irq_pending_o !== level) begin
            err_cnt++;
            $display("timeout: irq_pending_o did not reach %b within %0d cycles", level, limit);
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %s finished, %0d errors", name, err_cnt - test_err_base);
        test_err_base = err_cnt;
    endtask

    // ========================================
    // tests
    // ========================================
    task automatic test_reset();
        check_val("priv_lvl_o", PRIV_M, priv_lvl_o);
        check_val("ex_valid_o", 1'b0, ex_valid_o);
        check_val("eret_o", 1'b0, eret_o);
        check_val("irq_pending_o", 1'b0, irq_pending_o);
        expect_csr(ADDR_MTVEC, BOOT_ADDR + 64'h40, "mtvec");
        expect_csr(ADDR_MSTATUS, 64'h0, "mstatus");
        expect_csr(ADDR_MSCRATCH, 64'h0, "mscratch");
        finish_test("reset_values");
    endtask

    task automatic test_csr_cmds();
        logic [63:0] model;
        logic [63:0] r;
        model = '0;
        rand64(r);
        drive_op(CSR_CMD_WR, ADDR_MSCRATCH, r);
        model = r;
        expect_csr(ADDR_MSCRATCH, model, "mscratch after WR");
        rand64(r);
        drive_op(CSR_CMD_SET, ADDR_MSCRATCH, r);
        model = model | r;
        expect_csr(ADDR_MSCRATCH, model, "mscratch after SET");
        rand64(r);
        drive_op(CSR_CMD_CLR, ADDR_MSCRATCH, r);
        model = model & ~r;
        expect_csr(ADDR_MSCRATCH, model, "mscratch after CLR");
        rand64(r);
        drive_op(CSR_CMD_READ, ADDR_MSCRATCH, r);
        check_val("csr_rdata_o on READ", model, csr_rdata_o);
        expect_csr(ADDR_MSCRATCH, model, "mscratch after READ");
        // only the three machine enable bits stick
        drive_op(CSR_CMD_WR, ADDR_MIE, '1);
        expect_csr(ADDR_MIE, MIE_WRITE_MASK, "mie");
        rand64(r);
        drive_op(CSR_CMD_WR, ADDR_MCYCLE, r);
        expect_csr(ADDR_MCYCLE, r, "mcycle");
        expect_csr(ADDR_MCYCLE, r + 64'd1, "mcycle next cycle");
        finish_test("csr_commands");
    endtask

    task automatic test_illegal();
        logic [63:0] exp_vec;
        exp_vec = (BOOT_ADDR + 64'h40) & ~64'h3;
        // unknown address
        drive_op(CSR_CMD_READ, 12'h7C0, '0, 32'h7C00_2573);
        check_val("ex_valid_o", 1'b1, ex_valid_o);
        check_val("trap_vec_o", exp_vec, trap_vec_o);
        expect_csr(ADDR_MCAUSE, CAUSE_ILLEGAL_INSTR, "mcause");
        expect_csr(ADDR_MTVAL, 64'h7C00_2573, "mtval");
        // misa is read-only
        drive_op(CSR_CMD_WR, ADDR_MISA, 64'h0, 32'h3010_1073);
        check_val("ex_valid_o", 1'b1, ex_valid_o);
        check_val("trap_vec_o", exp_vec, trap_vec_o);
        expect_csr(ADDR_MCAUSE, CAUSE_ILLEGAL_INSTR, "mcause");
        expect_csr(ADDR_MTVAL, 64'h3010_1073, "mtval");
        finish_test("illegal_access");
    endtask

    task automatic test_trap_return();
        logic [63:0] r;
        drive_op(CSR_CMD_WR, ADDR_MSTATUS, 64'h0);
        // an mstatus write flushes younger instructions
        check_val("flush_o", 1'b1, flush_o);
        drive_op(CSR_CMD_WR, ADDR_MEPC, 64'h8000_1235);
        check_val("flush_o", 1'b0, flush_o);
        pulse_mret();
        check_val("eret_o", 1'b1, eret_o);
        check_val("epc_o", 64'h8000_1235 & ~64'h1, epc_o);
        drive_idle();
        check_val("priv_lvl_o", PRIV_U, priv_lvl_o);
        check_val("eret_o", 1'b0, eret_o);
        // machine csr from user mode
        drive_op(CSR_CMD_READ, ADDR_MSCRATCH, '0, 32'h3400_2573);
        check_val("ex_valid_o", 1'b1, ex_valid_o);
        drive_idle();
        check_val("priv_lvl_o", PRIV_M, priv_lvl_o);
        drive_op(CSR_CMD_READ, ADDR_MSTATUS, '0);
        r = csr_rdata_o;
        check_val("mstatus.mpp", PRIV_U, r[12:11]);
        raise_exception(CAUSE_ECALL_U, 64'h0, 64'h8000_2000);
        check_val("ex_valid_o", 1'b1, ex_valid_o);
        expect_csr(ADDR_MEPC, 64'h8000_2000, "mepc");
        expect_csr(ADDR_MCAUSE, CAUSE_ECALL_U, "mcause");
        finish_test("trap_return");
    endtask

    task automatic test_interrupts();
        logic [63:0] r;
        logic [63:0] base;
        base = 64'h8000_0100;
        @(negedge clk_i);
        irq_timer_i = 1'b1;
        drive_op(CSR_CMD_READ, ADDR_MIP, '0);
        r = csr_rdata_o;
        check_val("mip.mtip", 1'b1, r[IRQ_M_TIMER]);
        drive_op(CSR_CMD_WR, ADDR_MIE, 64'h80);
        drive_op(CSR_CMD_SET, ADDR_MSTATUS, 64'h8);
        drive_idle();
        wait_irq(1'b1, 10);
        drive_op(CSR_CMD_CLR, ADDR_MSTATUS, 64'h8);
        drive_idle();
        wait_irq(1'b0, 10);
        // vectored mode, timer interrupt number 7
        drive_op(CSR_CMD_WR, ADDR_MTVEC, base | 64'h1);
        expect_csr(ADDR_MTVEC, base | 64'h1, "mtvec vectored");
        raise_exception(64'h8000_0000_0000_0007, 64'h0, 64'h8000_3000);
        check_val("trap_vec_o", base + 64'd7 * 64'd4, trap_vec_o);
        drive_idle();
        @(negedge clk_i);
        irq_timer_i = 1'b0;
        finish_test("interrupts");
    endtask

    // ========================================
    // main sequence
    // ========================================
    initial begin
        err_cnt          = 0;
        check_cnt        = 0;
        test_err_base    = 0;
        lfsr_q           = 16'd83;
        mtvec_rst_load_q = 1'b1;
        boot_addr_i      = BOOT_ADDR;
        hart_id_i        = '0;
        csr_valid_i      = 1'b0;
        csr_cmd_i        = CSR_CMD_READ;
        csr_addr_i       = '0;
        csr_wdata_i      = '0;
        csr_instr_i      = '0;
        pc_i             = '0;
        ex_valid_i       = 1'b0;
        ex_cause_i       = '0;
        ex_tval_i        = '0;
        mret_i           = 1'b0;
        irq_ext_i        = 1'b0;
        irq_timer_i      = 1'b0;
        irq_soft_i       = 1'b0;
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        mtvec_rst_load_q = 1'b0;
        #1;

        test_reset();
        test_csr_cmds();
        test_illegal();
        test_trap_return();
        test_interrupts();

        err_cnt += u_csr_regfile_top.u_csr_regfile_checker.assert_fail_cnt;
        $display("summary: %0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
csr_pkg.sv
csr_access_check.sv
csr_machine_regs.sv
csr_trap_unit.sv
csr_regfile_top.sv
csr_regfile_checker.sv
tb_csr_regfile.sv
